//--- vlog.f
hdl/reflex_cfg_pkg.sv
hdl/reflex_types_pkg.sv
hdl/gain_decode.sv
hdl/synapse_execute.sv
hdl/mn_pool_result.sv
hdl/spinal_reflex_top.sv
verif/tb_spinal_reflex.sv

//--- verif/tb_spinal_reflex.sv
`default_nettype none

module tb_spinal_reflex;

    timeunit 1ns;
    timeprecision 100ps;

    logic                                  ep50trig;
    logic                                  reset_sim;
    reflex_types_pkg::param_wr_t           param;
    reflex_types_pkg::spike_in_t           spikes;
    wire [reflex_cfg_pkg::DATA_W-1:0]      drive;
    reflex_types_pkg::mn_result_t          result;

    // stimulus generator state
    logic [15:0] rng_state;
    // spike tallies for the size principle check
    int          mn0_spikes;
    int          mn2_spikes;

    // reference model state
    // currents in lane order ia ii cn cn2
    logic [31:0] m_cur   [4];
    logic [31:0] m_gain  [3];
    logic [31:0] m_drive;
    logic [15:0] m_lfsr  [3];
    logic [31:0] m_v     [3];
    logic [31:0] m_cnt   [3];
    logic [2:0]  m_spk;

    spinal_reflex_top uut
    (
        .i_ep50trig  (ep50trig),
        .i_reset_sim (reset_sim),
        .i_param     (param),
        .i_spikes    (spikes),
        .o_drive     (drive),
        .o_result    (result)
    );

    // 20 ns period
    initial
    begin
        ep50trig = 1'b0;
        forever
        begin
            #10 ep50trig = ~ep50trig;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random bits and reporting
    ////////////////////////////////////////////////////////////////////////////

    // galois lfsr stepped once per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], rng_state[0]};
            rng_state = (rng_state >> 1) ^ (rng_state[0] ? 16'hB400 : 16'h0000);
        end
        return v;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input logic [63:0] actual, input logic [63:0] expected,
                                 input string what);
        if (actual !== expected)
        begin
            $display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            stop_on_error("a checked value did not match its expected value");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic int unsigned weight_of(input int n);
        case (n)
            0:       return reflex_cfg_pkg::MN_WEIGHT_0;
            1:       return reflex_cfg_pkg::MN_WEIGHT_1;
            default: return reflex_cfg_pkg::MN_WEIGHT_2;
        endcase
    endfunction

    // per neuron count times weight in sixteenths
    function automatic logic [31:0] expected_weighted();
        logic [63:0] sum;
        logic [63:0] c;
        sum = '0;
        for (int n = 0; n < 3; n++)
        begin
            c   = m_cnt[n];
            sum = sum + ((c * weight_of(n)) >> 4);
        end
        return sum[31:0];
    endfunction

    task automatic model_reset();
        for (int k = 0; k < 4; k++)
        begin
            m_cur[k] = '0;
        end
        for (int n = 0; n < 3; n++)
        begin
            m_gain[n] = 32'd1;
            m_v[n]    = '0;
            m_cnt[n]  = '0;
        end
        m_lfsr[0] = reflex_cfg_pkg::LFSR_SEED_0;
        m_lfsr[1] = reflex_cfg_pkg::LFSR_SEED_1;
        m_lfsr[2] = reflex_cfg_pkg::LFSR_SEED_2;
        m_drive   = '0;
        m_spk     = '0;
    endtask

    // one clock edge where every stage works on the values held before it
    task automatic model_step(input reflex_types_pkg::param_wr_t p,
                              input reflex_types_pkg::spike_in_t s);
        logic [3:0]  sv;
        logic [31:0] sum;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] din;
        logic [63:0] vn;
        int          gi;
        sv  = {s.cn2, s.cn, s.ii, s.ia};
        sum = '0;
        // drive from the old currents and old gains
        for (int k = 0; k < 4; k++)
        begin
            gi  = (k < 2) ? 0 : k - 1;
            a   = m_cur[k];
            b   = m_gain[gi];
            sum = sum + 32'(a * b);
        end
        // motoneurons see the old drive
        for (int n = 0; n < 3; n++)
        begin
            din = {m_drive[31:10], m_lfsr[n][9:0]};
            vn  = m_v[n];
            vn  = vn - (vn >> 4) + ((din * weight_of(n)) >> 4);
            if (vn >= 64'd30720)
            begin
                m_spk[n] = 1'b1;
                m_v[n]   = '0;
                m_cnt[n] = m_cnt[n] + 1;
            end
            else
            begin
                m_spk[n] = 1'b0;
                m_v[n]   = vn[31:0];
            end
            m_lfsr[n] = (m_lfsr[n] >> 1) ^ (m_lfsr[n][0] ? 16'hB400 : 16'h0000);
        end
        for (int k = 0; k < 4; k++)
        begin
            m_cur[k] = m_cur[k] - (m_cur[k] >> 3) + (sv[k] ? 32'd1024 : 32'd0);
        end
        m_drive = sum;
        // gains in the order sn cn cn2
        if (p.wr)
        begin
            case (p.sel)
                4'd6:    m_gain[0] = p.data;
                4'd3:    m_gain[1] = p.data;
                4'd9:    m_gain[2] = p.data;
                default: ;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // cycle driver
    ////////////////////////////////////////////////////////////////////////////

    // entered and left 2 ns after a rising edge
    task automatic run_cycle(input reflex_types_pkg::param_wr_t p,
                             input reflex_types_pkg::spike_in_t s);
        param  = p;
        spikes = s;
        @(posedge ep50trig);
        #1;
        model_step(p, s);
        compare_value(drive, m_drive, "o_drive");
        compare_value(result.spike, m_spk, "spike bits");
        compare_value(result.weighted_count, expected_weighted(), "weighted_count");
        #1;
    endtask

    task automatic check_reset_outputs();
        compare_value(drive, 0, "o_drive in reset");
        compare_value(result.spike, 0, "spike bits in reset");
        compare_value(result.weighted_count, 0, "weighted_count in reset");
    endtask

    // asynchronous assert and release 2 ns after an edge
    task automatic apply_reset(input int cycles);
        reset_sim = 1'b1;
        param     = '0;
        spikes    = '0;
        #1;
        check_reset_outputs();
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge ep50trig);
        end
        #2;
        reset_sim = 1'b0;
        model_reset();
        check_reset_outputs();
    endtask

    task automatic write_gain(input logic [3:0] sel, input logic [31:0] data,
                              input reflex_types_pkg::spike_in_t s);
        reflex_types_pkg::param_wr_t p;
        p.wr   = 1'b1;
        p.sel  = sel;
        p.data = data;
        run_cycle(p, s);
    endtask

    // ia on every cycle and ii at random
    task automatic sustained_cycle();
        reflex_types_pkg::spike_in_t s;
        s     = '0;
        s.ia  = 1'b1;
        s.ii  = 1'(rand_bits(1));
        run_cycle('0, s);
        if (result.spike[0])
        begin
            mn0_spikes++;
        end
        if (result.spike[2])
        begin
            mn2_spikes++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        check_reset_outputs();
        for (int i = 0; i < 4; i++)
        begin
            run_cycle('0, '0);
        end
    endtask

    // quantum shows up two edges after the spike
    task automatic test_single_ia();
        reflex_types_pkg::spike_in_t s;
        int edges;
        s    = '0;
        s.ia = 1'b1;
        run_cycle('0, s);
        edges = 1;
        while (drive == 0 && edges < 8)
        begin
            run_cycle('0, '0);
            edges++;
        end
        if (drive == 0)
        begin
            stop_on_error("timeout: the Ia spike never reached o_drive");
        end
        compare_value(edges, 2, "edges from Ia spike to drive");
        compare_value(drive, 1024, "drive after one Ia spike");
        // decay tail checked against the model
        for (int i = 0; i < 12; i++)
        begin
            run_cycle('0, '0);
        end
    endtask

    task automatic test_random_gains();
        write_gain(4'd6, rand_bits(32), '0);
        write_gain(4'd3, rand_bits(32), '0);
        write_gain(4'd9, rand_bits(32), '0);
        for (int i = 0; i < 40; i++)
        begin
            run_cycle('0, 4'(rand_bits(4)));
        end
    endtask

    // foreign selectors must not touch any gain
    task automatic test_unused_selector();
        write_gain(4'd5, rand_bits(32), 4'(rand_bits(4)));
        write_gain(4'd0, rand_bits(32), 4'(rand_bits(4)));
        write_gain(4'd15, rand_bits(32), 4'(rand_bits(4)));
        for (int i = 0; i < 20; i++)
        begin
            run_cycle('0, 4'(rand_bits(4)));
        end
    endtask

    task automatic test_sustained_drive();
        int waited;
        write_gain(4'd6, 32'd1, '0);
        write_gain(4'd3, 32'd0, '0);
        write_gain(4'd9, 32'd0, '0);
        mn0_spikes = 0;
        mn2_spikes = 0;
        waited     = 0;
        // smallest motoneuron must get recruited
        while (mn2_spikes == 0 && waited < 120)
        begin
            sustained_cycle();
            waited++;
        end
        if (mn2_spikes == 0)
        begin
            stop_on_error("timeout: motoneuron 2 never fired under sustained drive");
        end
        for (int i = 0; i < 150; i++)
        begin
            sustained_cycle();
        end
        compare_value(mn0_spikes >= mn2_spikes, 1, "motoneuron 0 fires at least as often");
    endtask

    task automatic test_reset_midrun();
        for (int i = 0; i < 10; i++)
        begin
            run_cycle('0, 4'(rand_bits(4)));
        end
        apply_reset(3);
        for (int i = 0; i < 10; i++)
        begin
            run_cycle('0, 4'(rand_bits(4)));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        reset_sim  = 1'b0;
        param      = '0;
        spikes     = '0;
        rng_state  = 16'd59045;
        mn0_spikes = 0;
        mn2_spikes = 0;
        // reset edge lands after time zero
        #2;
        apply_reset(5);
        test_reset_state();
        test_single_ia();
        test_random_gains();
        test_unused_selector();
        test_sustained_drive();
        test_reset_midrun();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/spinal_reflex_top.sv
`default_nettype none

module spinal_reflex_top
(
    input  wire                               i_ep50trig,
    input  wire                               i_reset_sim,
    input  wire reflex_types_pkg::param_wr_t  i_param,
    input  wire reflex_types_pkg::spike_in_t  i_spikes,
    output wire [reflex_cfg_pkg::DATA_W-1:0]  o_drive,
    output wire reflex_types_pkg::mn_result_t o_result
);

    // gains from the host registers into the synapses
    wire reflex_types_pkg::gain_set_t gains;

    ////////////////////////////////////////////////////////////////////////////
    // decode, host writes into gains
    ////////////////////////////////////////////////////////////////////////////

    gain_decode u_gain_decode
    (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_param     (i_param),
        .o_gains     (gains)
    );

    ////////////////////////////////////////////////////////////////////////////
    // execute, synaptic currents into drive
    ////////////////////////////////////////////////////////////////////////////

    synapse_execute u_synapse_execute
    (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_spikes    (i_spikes),
        .i_gains     (gains),
        .o_drive     (o_drive)
    );

    ////////////////////////////////////////////////////////////////////////////
    // result, motoneuron pool on the latched drive
    ////////////////////////////////////////////////////////////////////////////

    // pool reads the same register that leaves the top
    mn_pool_result u_mn_pool_result
    (
        .i_ep50trig  (i_ep50trig),
        .i_reset_sim (i_reset_sim),
        .i_drive     (o_drive),
        .o_result    (o_result)
    );

endmodule

`default_nettype wire

//--- hdl/mn_pool_result.sv
`default_nettype none

module mn_pool_result
(
    input  wire                               i_ep50trig,
    input  wire                               i_reset_sim,
    input  wire [reflex_cfg_pkg::DATA_W-1:0]  i_drive,
    output reflex_types_pkg::mn_result_t      o_result
);

    // per-neuron views of the package constants
    localparam int unsigned MN_WEIGHT [reflex_cfg_pkg::MN_COUNT] = '{
        reflex_cfg_pkg::MN_WEIGHT_0,
        reflex_cfg_pkg::MN_WEIGHT_1,
        reflex_cfg_pkg::MN_WEIGHT_2
    };
    localparam logic [reflex_cfg_pkg::LFSR_W-1:0] MN_SEED [reflex_cfg_pkg::MN_COUNT] = '{
        reflex_cfg_pkg::LFSR_SEED_0,
        reflex_cfg_pkg::LFSR_SEED_1,
        reflex_cfg_pkg::LFSR_SEED_2
    };

    logic [reflex_cfg_pkg::LFSR_W-1:0]    lfsr       [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::DATA_W-1:0]    mn_dith    [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::MN_PROD_W-1:0] mn_in      [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::MN_PROD_W-1:0] v_next     [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::DATA_W-1:0]    v_mem      [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::DATA_W-1:0]    spk_cnt    [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::MN_PROD_W-1:0] cnt_scaled [reflex_cfg_pkg::MN_COUNT];
    logic [reflex_cfg_pkg::MN_COUNT-1:0]  spk_q;
    logic [reflex_cfg_pkg::DATA_W-1:0]    weighted_sum;

    // one galois step, taps xored in when a 1 falls out
    function automatic logic [reflex_cfg_pkg::LFSR_W-1:0] lfsr_step
    (
        input logic [reflex_cfg_pkg::LFSR_W-1:0] state
    );
        return (state >> 1) ^ (state[0] ? reflex_cfg_pkg::LFSR_TAPS : '0);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // dithered, weighted input and membrane update
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int n = 0; n < reflex_cfg_pkg::MN_COUNT; n++)
        begin
            // low drive bits swapped for noise
            mn_dith[n] = {i_drive[reflex_cfg_pkg::DATA_W-1:reflex_cfg_pkg::DITHER_BITS],
                          lfsr[n][reflex_cfg_pkg::DITHER_BITS-1:0]};
            // weight in sixteenths, wide so large drive does not wrap
            mn_in[n]   = (mn_dith[n] * MN_WEIGHT[n]) >> reflex_cfg_pkg::WEIGHT_SHIFT;
            // leaky integrate
            v_next[n]  = v_mem[n] - (v_mem[n] >> reflex_cfg_pkg::MN_LEAK_SHIFT) + mn_in[n];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // lfsr, membrane, spike and counter registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            for (int n = 0; n < reflex_cfg_pkg::MN_COUNT; n++)
            begin
                lfsr[n]    <= MN_SEED[n];
                v_mem[n]   <= '0;
                spk_cnt[n] <= '0;
            end
            spk_q <= '0;
        end
        else
        begin
            for (int n = 0; n < reflex_cfg_pkg::MN_COUNT; n++)
            begin
                lfsr[n] <= lfsr_step(lfsr[n]);
                // fire and reset to rest
                if (v_next[n] >= reflex_cfg_pkg::MN_THRESHOLD)
                begin
                    spk_q[n]   <= 1'b1;
                    v_mem[n]   <= '0;
                    spk_cnt[n] <= spk_cnt[n] + 1'b1;
                end
                // below threshold, v_next fits in DATA_W here
                else
                begin
                    spk_q[n] <= 1'b0;
                    v_mem[n] <= v_next[n][reflex_cfg_pkg::DATA_W-1:0];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // weighted spike total
    ////////////////////////////////////////////////////////////////////////////

    // same weights as the drive side
    always_comb
    begin
        weighted_sum = '0;
        for (int n = 0; n < reflex_cfg_pkg::MN_COUNT; n++)
        begin
            cnt_scaled[n] = (spk_cnt[n] * MN_WEIGHT[n]) >> reflex_cfg_pkg::WEIGHT_SHIFT;
            weighted_sum  = weighted_sum + cnt_scaled[n][reflex_cfg_pkg::DATA_W-1:0];
        end
    end

    assign o_result = '{spike: spk_q, weighted_count: weighted_sum};

    // membrane starts from 0 after a spike, so a second spike in a row
    // needs the input alone to reach threshold
    for (genvar n = 0; n < reflex_cfg_pkg::MN_COUNT; n++)
    begin : g_spike_chk
        a_back_to_back : assert property (
            @(posedge i_ep50trig) disable iff (i_reset_sim)
            spk_q[n] ##1 spk_q[n] |-> $past(mn_in[n]) >= reflex_cfg_pkg::MN_THRESHOLD
        );
    end

endmodule

`default_nettype wire

//--- hdl/synapse_execute.sv
`default_nettype none

module synapse_execute
(
    input  wire                               i_ep50trig,
    input  wire                               i_reset_sim,
    input  wire reflex_types_pkg::spike_in_t  i_spikes,
    input  wire reflex_types_pkg::gain_set_t  i_gains,
    output logic [reflex_cfg_pkg::DATA_W-1:0] o_drive
);

    // ia, ii, cn, cn2
    localparam int NUM_SYN = 4;

    logic [NUM_SYN-1:0]                spk_vec;
    logic [reflex_cfg_pkg::DATA_W-1:0] syn_cur  [NUM_SYN];
    logic [reflex_cfg_pkg::DATA_W-1:0] syn_gain [NUM_SYN];
    logic [reflex_cfg_pkg::DATA_W-1:0] syn_prod [NUM_SYN];
    logic [reflex_cfg_pkg::DATA_W-1:0] drive_sum;

    ////////////////////////////////////////////////////////////////////////////
    // lane mapping
    ////////////////////////////////////////////////////////////////////////////

    // lane 0 is spindle ia
    always_comb
    begin
        spk_vec = {i_spikes.cn2, i_spikes.cn, i_spikes.ii, i_spikes.ia};
    end

    // both spindle afferents share the sensory gain
    always_comb
    begin
        syn_gain[0] = i_gains.sn_to_mn;
        syn_gain[1] = i_gains.sn_to_mn;
        syn_gain[2] = i_gains.cn_to_mn;
        syn_gain[3] = i_gains.cn2_to_mn;
    end

    ////////////////////////////////////////////////////////////////////////////
    // decaying synaptic currents
    ////////////////////////////////////////////////////////////////////////////

    // first order decay plus one quantum per spike
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            for (int k = 0; k < NUM_SYN; k++)
            begin
                syn_cur[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < NUM_SYN; k++)
            begin
                syn_cur[k] <= syn_cur[k]
                            - (syn_cur[k] >> reflex_cfg_pkg::SYN_DECAY_SHIFT)
                            + (spk_vec[k] ? reflex_cfg_pkg::EPSC_QUANTUM : '0);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // gain and summation
    ////////////////////////////////////////////////////////////////////////////

    // low 32 bits of each product, sum wraps
    always_comb
    begin
        drive_sum = '0;
        for (int k = 0; k < NUM_SYN; k++)
        begin
            syn_prod[k] = syn_cur[k] * syn_gain[k];
            drive_sum   = drive_sum + syn_prod[k];
        end
    end

    // motoneuron drive latch
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            o_drive <= '0;
        end
        else
        begin
            o_drive <= drive_sum;
        end
    end

    // steady state under a spike every cycle sits at quantum << shift
    for (genvar k = 0; k < NUM_SYN; k++)
    begin : g_cur_bound
        a_cur_bound : assert property (
            @(posedge i_ep50trig) disable iff (i_reset_sim)
            syn_cur[k] <= (reflex_cfg_pkg::EPSC_QUANTUM << reflex_cfg_pkg::SYN_DECAY_SHIFT)
        );
    end

endmodule

`default_nettype wire

//--- hdl/gain_decode.sv
`default_nettype none

module gain_decode
(
    input  wire                              i_ep50trig,
    input  wire                              i_reset_sim,
    input  wire reflex_types_pkg::param_wr_t i_param,
    output reflex_types_pkg::gain_set_t      o_gains
);

    // selector names one of the three gains
    logic sel_hit;

    always_comb
    begin
        sel_hit = i_param.wr &&
                  (i_param.sel inside {reflex_cfg_pkg::SEL_GAIN_CN_TO_MN,
                                       reflex_cfg_pkg::SEL_GAIN_SN_TO_MN,
                                       reflex_cfg_pkg::SEL_GAIN_CN2_TO_MN});
    end

    ////////////////////////////////////////////////////////////////////////////
    // gain register set
    ////////////////////////////////////////////////////////////////////////////

    // loads on the strobe edge itself
    always_ff @(posedge i_ep50trig or posedge i_reset_sim)
    begin
        if (i_reset_sim)
        begin
            o_gains.sn_to_mn  <= reflex_cfg_pkg::GAIN_RESET;
            o_gains.cn_to_mn  <= reflex_cfg_pkg::GAIN_RESET;
            o_gains.cn2_to_mn <= reflex_cfg_pkg::GAIN_RESET;
        end
        else if (i_param.wr)
        begin
            case (i_param.sel)
                reflex_cfg_pkg::SEL_GAIN_CN_TO_MN:
                    o_gains.cn_to_mn <= i_param.data;
                reflex_cfg_pkg::SEL_GAIN_SN_TO_MN:
                    o_gains.sn_to_mn <= i_param.data;
                reflex_cfg_pkg::SEL_GAIN_CN2_TO_MN:
                    o_gains.cn2_to_mn <= i_param.data;
                // other trigger numbers belong to dropped parameters
                default:
                    ;
            endcase
        end
    end

    // no strobe, or a foreign selector, leaves the whole set untouched
    a_gains_hold : assert property (
        @(posedge i_ep50trig) disable iff (i_reset_sim)
        !sel_hit |=> $stable(o_gains)
    );

endmodule

`default_nettype wire

//--- hdl/reflex_types_pkg.sv
`default_nettype none

package reflex_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // stimulus side
    ////////////////////////////////////////////////////////////////////////////

    // presynaptic spike pulses, one cycle each
    typedef struct packed {
        logic ia;
        logic ii;
        logic cn;
        logic cn2;
    } spike_in_t;

    // host write, sel and data valid while wr is high
    typedef struct packed {
        logic                                 wr;
        logic [reflex_cfg_pkg::SEL_W-1:0]     sel;
        logic [reflex_cfg_pkg::DATA_W-1:0]    data;
    } param_wr_t;

    ////////////////////////////////////////////////////////////////////////////
    // between the stages
    ////////////////////////////////////////////////////////////////////////////

    // synaptic gains, ia and ii share sn_to_mn
    typedef struct packed {
        logic [reflex_cfg_pkg::DATA_W-1:0]    sn_to_mn;
        logic [reflex_cfg_pkg::DATA_W-1:0]    cn_to_mn;
        logic [reflex_cfg_pkg::DATA_W-1:0]    cn2_to_mn;
    } gain_set_t;

    // pool output, spike bit n belongs to motoneuron n
    typedef struct packed {
        logic [reflex_cfg_pkg::MN_COUNT-1:0]  spike;
        logic [reflex_cfg_pkg::DATA_W-1:0]    weighted_count;
    } mn_result_t;

endpackage

`default_nettype wire

//--- hdl/reflex_cfg_pkg.sv
`default_nettype none

package reflex_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // currents, gains, drive and spike counts
    localparam int DATA_W = 32;
    // host parameter selector
    localparam int SEL_W = 4;

    ////////////////////////////////////////////////////////////////////////////
    // host parameter writes
    ////////////////////////////////////////////////////////////////////////////

    // selector codes keep the old trigger numbering
    localparam logic [SEL_W-1:0] SEL_GAIN_CN_TO_MN  = 4'd3;
    localparam logic [SEL_W-1:0] SEL_GAIN_SN_TO_MN  = 4'd6;
    localparam logic [SEL_W-1:0] SEL_GAIN_CN2_TO_MN = 4'd9;

    // unity gain out of reset
    localparam logic [DATA_W-1:0] GAIN_RESET = 32'd1;

    ////////////////////////////////////////////////////////////////////////////
    // synapse rule
    ////////////////////////////////////////////////////////////////////////////

    // current added per presynaptic spike
    localparam logic [DATA_W-1:0] EPSC_QUANTUM = 32'd1024;
    // decay per cycle is cur >> SYN_DECAY_SHIFT
    localparam int SYN_DECAY_SHIFT = 3;

    ////////////////////////////////////////////////////////////////////////////
    // motoneuron pool
    ////////////////////////////////////////////////////////////////////////////

    // low drive bits replaced by lfsr noise
    localparam int DITHER_BITS = 10;
    localparam int MN_COUNT = 3;

    // size principle, weights in sixteenths
    localparam int MN_WEIGHT_0 = 75;
    localparam int MN_WEIGHT_1 = 30;
    localparam int MN_WEIGHT_2 = 13;
    localparam int WEIGHT_SHIFT = 4;
    // room for drive times weight without wrap
    localparam int MN_PROD_W = DATA_W + 8;

    // 30 mV, scaled by 1024
    localparam logic [DATA_W-1:0] MN_THRESHOLD = 32'd30720;
    localparam int MN_LEAK_SHIFT = 4;

    // galois lfsr, one seed per motoneuron
    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_TAPS   = 16'hB400;
    localparam logic [LFSR_W-1:0] LFSR_SEED_0 = 16'hACE1;
    localparam logic [LFSR_W-1:0] LFSR_SEED_1 = 16'h1D2C;
    localparam logic [LFSR_W-1:0] LFSR_SEED_2 = 16'h7F3B;

endpackage

`default_nettype wire
